// ==== hw/noc_buffer.sv ====
// shift-register flit FIFO with valid/ready on both sides; depth must be at least 1, data has no reset.
`default_nettype none

module noc_buffer #(
   parameter int depth = 4
) (
   input  wire                 clk,
   input  wire                 rst,

   // write side.
   input  wire noc_pkg::flit_t in_flit,
   input  wire                 in_valid,
   output logic                in_ready,

   // read side.
   output noc_pkg::flit_t      out_flit,
   output logic                out_valid,
   input  wire                 out_ready
);

   // storage, slot 0 is the head.
   noc_pkg::flit_t slots [depth];
   noc_pkg::flit_t slots_nxt [depth];

   // one-hot occupancy pointer.
   // bit k set means k entries held, so bit 0 is empty and bit depth is full.
   logic [depth:0] occ;

   logic push;
   logic pop;

   assign push = in_valid & in_ready;
   assign pop  = out_valid & out_ready;

   // head drives the output directly.
   assign out_flit  = slots[0];
   assign out_valid = ~occ[0];
   // ready drops only when every slot is taken.
   assign in_ready  = ~occ[depth];

   // pointer moves only when push and pop differ.
   always_ff @(posedge clk) begin
      if (rst) begin
         occ <= {{depth{1'b0}}, 1'b1};
      end else if (push && !pop) begin
         occ <= occ << 1;
      end else if (pop && !push) begin
         occ <= occ >> 1;
      end
   end

   // next slot contents.
   always_comb begin
      slots_nxt = slots;
      // a pop moves every entry one step toward the head.
      if (pop) begin
         for (int i = 0; i < depth - 1; i++) begin
            slots_nxt[i] = slots[i + 1];
         end
      end
      // a push lands in the first free slot.
      // with a pop in the same cycle that slot is one lower.
      if (push) begin
         for (int i = 0; i < depth; i++) begin
            if (pop ? occ[i + 1] : occ[i]) begin
               slots_nxt[i] = in_flit;
            end
         end
      end
   end

   // no reset on payload.
   always_ff @(posedge clk) begin
      slots <= slots_nxt;
   end

   // pointer never holds zero or two bits.
   a_occ_onehot: assert property (@(posedge clk) disable iff (rst)
      $onehot(occ));

   // a stalled head must not change under the consumer.
   a_head_stable: assert property (@(posedge clk) disable iff (rst)
      out_valid && !out_ready |=> $stable(out_flit));

endmodule

`default_nettype wire

// ==== hw/noc_input_port.sv ====
// router input port; expects well-formed packets, a route is held from head flit to tail flit.
`default_nettype none

module noc_input_port (
   input  wire                 clk,
   input  wire                 rst,

   // link from the outside.
   input  wire noc_pkg::flit_t in_flit,
   input  wire                 in_valid,
   output logic                in_ready,

   // toward the output arbiters.
   output noc_pkg::flit_t      head_flit,
   output noc_pkg::port_mask_t request,
   input  wire                 grant
);

   // buffer head.
   logic buf_valid;

   // route machine.
   noc_pkg::route_state_t state;
   noc_pkg::port_t        route_q;
   noc_pkg::port_t        route_head;
   noc_pkg::port_t        route_cur;

   logic pop;

   noc_buffer #(
      .depth     (noc_pkg::in_buf_depth)
   ) i_buf (
      .clk       (clk),
      .rst       (rst),
      .in_flit   (in_flit),
      .in_valid  (in_valid),
      .in_ready  (in_ready),
      .out_flit  (head_flit),
      .out_valid (buf_valid),
      // a grant is the ready of the buffer.
      .out_ready (grant)
   );

   // a granted flit leaves this cycle.
   assign pop = grant & buf_valid;

   // destination from the low data bits of a head flit.
   assign route_head = head_flit.data[$bits(noc_pkg::port_t)-1:0];

   // idle decodes on the fly, in_packet uses the stored route.
   assign route_cur = (state == noc_pkg::idle) ? route_head : route_q;

   // one-hot toward the routed output while a flit waits.
   always_comb begin
      request = '0;
      if (buf_valid) begin
         request[route_cur] = 1'b1;
      end
   end

   // route is kept until the tail flit pops.
   always_ff @(posedge clk) begin
      if (rst) begin
         state   <= noc_pkg::idle;
         route_q <= '0;
      end else begin
         case (state)
            noc_pkg::idle: begin
               // single-flit packets stay in idle.
               if (pop && !head_flit.last) begin
                  state   <= noc_pkg::in_packet;
                  route_q <= route_head;
               end
            end
            noc_pkg::in_packet: begin
               if (pop && head_flit.last) begin
                  state <= noc_pkg::idle;
               end
            end
            default: begin
               state <= noc_pkg::idle;
            end
         endcase
      end
   end

   // between packets the next flit at the head opens a packet.
   a_idle_head_first: assert property (@(posedge clk) disable iff (rst)
      (state == noc_pkg::idle) && buf_valid |-> head_flit.first);

endmodule

`default_nettype wire

// ==== hw/noc_output_arbiter.sv ====
// per-output round-robin arbiter with packet lock; an input must hold its request until its tail flit goes.
`default_nettype none

module noc_output_arbiter (
   input  wire                      clk,
   input  wire                      rst,

   // bit i requests from input i.
   input  wire noc_pkg::port_mask_t request,
   input  wire noc_pkg::flit_t      head_flits [noc_pkg::num_ports],
   output noc_pkg::port_mask_t      grant,

   // link to the outside.
   output noc_pkg::flit_t           out_flit,
   output logic                     out_valid,
   input  wire                      out_ready
);

   // lock state.
   logic           locked;
   noc_pkg::port_t owner;

   // round-robin pointer to the input checked first.
   noc_pkg::port_t prio;

   // selection.
   noc_pkg::port_t sel;
   logic           sel_hit;
   noc_pkg::flit_t sel_flit;

   // room in the output buffer.
   logic buf_ready;
   logic push;

   // pick the input that may go next.
   always_comb begin
      sel     = owner;
      sel_hit = 1'b0;
      if (locked) begin
         // only the owner continues its packet.
         sel_hit = request[owner];
      end else begin
         // first requester at or after prio with wraparound.
         for (int k = 0; k < noc_pkg::num_ports; k++) begin
            if (!sel_hit && request[noc_pkg::port_t'(prio + k)]) begin
               sel     = noc_pkg::port_t'(prio + k);
               sel_hit = 1'b1;
            end
         end
      end
   end

   // grant only with room downstream.
   always_comb begin
      grant = '0;
      if (sel_hit && buf_ready) begin
         grant[sel] = 1'b1;
      end
   end

   // flit mux.
   assign sel_flit = head_flits[sel];
   assign push     = |grant;

   // lock and pointer update.
   always_ff @(posedge clk) begin
      if (rst) begin
         locked <= 1'b0;
         owner  <= '0;
         prio   <= '0;
      end else if (push) begin
         // a new packet moves the pointer past the winner.
         if (!locked) begin
            prio  <= sel + 1'b1;
            owner <= sel;
         end
         // tail releases the output.
         locked <= ~sel_flit.last;
      end
   end

   noc_buffer #(
      .depth     (noc_pkg::out_buf_depth)
   ) i_buf (
      .clk       (clk),
      .rst       (rst),
      .in_flit   (sel_flit),
      .in_valid  (push),
      .in_ready  (buf_ready),
      .out_flit  (out_flit),
      .out_valid (out_valid),
      .out_ready (out_ready)
   );

   // one winner at most.
   a_grant_onehot0: assert property (@(posedge clk) disable iff (rst)
      $onehot0(grant));

   // never grant an idle input.
   a_grant_requested: assert property (@(posedge clk) disable iff (rst)
      (grant & ~request) == '0);

endmodule

`default_nettype wire

// ==== hw/noc_pkg.sv ====
// shared flit types and sizes for the 4-port router; destination sits in the head flit's low data bits.
`default_nettype none

package noc_pkg;

   // number of router ports, in and out.
   localparam int num_ports = 4;

   // flit buffer depths.
   // input side absorbs a short burst.
   localparam int in_buf_depth = 4;
   // output side only decouples the arbiter from the link.
   localparam int out_buf_depth = 2;

   // payload width of one flit.
   localparam int flit_data_width = 32;

   // port number, wide enough for num_ports.
   typedef logic [$clog2(num_ports)-1:0] port_t;

   // raw flit payload.
   typedef logic [flit_data_width-1:0] flit_data_t;

   // one bit per port, used for request and grant vectors.
   typedef logic [num_ports-1:0] port_mask_t;

   // a single flit on a link.
   // a single-flit packet has both first and last set.
   // in a head flit the low data bits carry the destination port.
   typedef struct packed {
      logic       first;
      logic       last;
      flit_data_t data;
   } flit_t;

   // route machine of an input port.
   // idle means the next flit at the head must be a head flit.
   typedef enum logic {
      idle,
      in_packet
   } route_state_t;

endpackage

`default_nettype wire

// ==== hw/noc_router.sv ====
// 4-port wormhole router top; single hop only, destination port taken from the head flit.
`default_nettype none

module noc_router (
   input  wire                               clk,
   input  wire                               rst,

   // input links indexed by port.
   input  wire noc_pkg::flit_t               in_flit  [noc_pkg::num_ports],
   input  wire [noc_pkg::num_ports-1:0]      in_valid,
   output logic [noc_pkg::num_ports-1:0]     in_ready,

   // output links indexed by port.
   output noc_pkg::flit_t                    out_flit [noc_pkg::num_ports],
   output logic [noc_pkg::num_ports-1:0]     out_valid,
   input  wire [noc_pkg::num_ports-1:0]      out_ready
);

   // head flit of each input as seen by every arbiter.
   noc_pkg::flit_t      head_flits [noc_pkg::num_ports];

   // request from input i with one bit per output.
   noc_pkg::port_mask_t in_request [noc_pkg::num_ports];
   // request seen by output j with one bit per input.
   noc_pkg::port_mask_t out_request [noc_pkg::num_ports];

   // grant from output j with one bit per input.
   noc_pkg::port_mask_t out_grant [noc_pkg::num_ports];
   // merged grant per input.
   logic [noc_pkg::num_ports-1:0] in_grant;

   // transpose the request matrix.
   always_comb begin
      for (int j = 0; j < noc_pkg::num_ports; j++) begin
         for (int i = 0; i < noc_pkg::num_ports; i++) begin
            out_request[j][i] = in_request[i][j];
         end
      end
   end

   // an input is granted by whichever output it routes to.
   always_comb begin
      in_grant = '0;
      for (int j = 0; j < noc_pkg::num_ports; j++) begin
         in_grant = in_grant | out_grant[j];
      end
   end

   for (genvar p = 0; p < noc_pkg::num_ports; p++) begin : g_port
      noc_input_port i_in (
         .clk       (clk),
         .rst       (rst),
         .in_flit   (in_flit[p]),
         .in_valid  (in_valid[p]),
         .in_ready  (in_ready[p]),
         .head_flit (head_flits[p]),
         .request   (in_request[p]),
         .grant     (in_grant[p])
      );

      noc_output_arbiter i_out (
         .clk        (clk),
         .rst        (rst),
         .request    (out_request[p]),
         .head_flits (head_flits),
         .grant      (out_grant[p]),
         .out_flit   (out_flit[p]),
         .out_valid  (out_valid[p]),
         .out_ready  (out_ready[p])
      );
   end

endmodule

`default_nettype wire

// ==== src.f ====
hw/noc_pkg.sv
hw/noc_buffer.sv
hw/noc_input_port.sv
hw/noc_output_arbiter.sv
hw/noc_router.sv
+incdir+tb
tb/noc_router_tb.sv

// ==== tb/noc_tb_util.svh ====
// testbench helpers; included inside the testbench module after lfsr_state and the error counters.
`ifndef NOC_TB_UTIL_SVH
`define NOC_TB_UTIL_SVH

// packet being sent by one source.
// len of zero means no packet open.
typedef struct packed {
   noc_pkg::port_t dst;
   logic [2:0]     len;
   logic [2:0]     pos;
} pkt_rec_t;

// 16-bit fibonacci lfsr with taps 16 14 13 11.
function automatic logic [15:0] lfsr_next(input logic [15:0] s);
   logic fb;
   fb = s[15] ^ s[13] ^ s[12] ^ s[10];
   return {s[14:0], fb};
endfunction

// n random bits with one lfsr step per bit.
function automatic logic [31:0] rand_bits(input int n);
   logic [31:0] v;
   v = '0;
   for (int k = 0; k < n; k++) begin
      lfsr_state = lfsr_next(lfsr_state);
      v = {v[30:0], lfsr_state[0]};
   end
   return v;
endfunction

// wrong value on a named signal.
task automatic report_mismatch(input string name, input logic [33:0] got,
                               input logic [33:0] exp);
   mismatch_count++;
   $display("MISMATCH at %0d ns: %s got %h expected %h", $time, name, got, exp);
endtask

// any other failure described in words.
task automatic report_error(input string what);
   error_count++;
   $display("ERROR at %0d ns: %s", $time, what);
endtask

`endif

// ==== tb/noc_router_tb.sv ====
// random traffic testbench for the 4-port router; model keys flits by source bits 3:2 of the payload.
`default_nettype none

module noc_router_tb;
   timeunit 1ns;
   timeprecision 1ps;

   // per-pair expected queue size and random packets per source.
   localparam int q_depth   = 256;
   localparam int rand_pkts = 40;

   // dut links.
   logic                           clk;
   logic                           rst;
   noc_pkg::flit_t                 in_flit  [noc_pkg::num_ports];
   logic [noc_pkg::num_ports-1:0]  in_valid;
   logic [noc_pkg::num_ports-1:0]  in_ready;
   noc_pkg::flit_t                 out_flit [noc_pkg::num_ports];
   logic [noc_pkg::num_ports-1:0]  out_valid;
   logic [noc_pkg::num_ports-1:0]  out_ready;

   // random state and counters.
   logic [15:0] lfsr_state;
   int          mismatch_count;
   int          error_count;
   int          flits_sent;
   int          flits_recv;
   int          cycle_count;

   `include "noc_tb_util.svh"

   // expected flits in one ring per input/output pair at index src*4+dst.
   noc_pkg::flit_t exp_mem [noc_pkg::num_ports*noc_pkg::num_ports][q_depth];
   int             exp_wr  [noc_pkg::num_ports*noc_pkg::num_ports];
   int             exp_rd  [noc_pkg::num_ports*noc_pkg::num_ports];

   // source side.
   pkt_rec_t                      cur [noc_pkg::num_ports];
   int                            pkts_left [noc_pkg::num_ports];
   logic [11:0]                   seq [noc_pkg::num_ports];
   logic                          directed;
   logic [noc_pkg::num_ports-1:0] in_fire;

   // sink side.
   logic                          fair_phase;
   int                            fair_idx;
   logic [noc_pkg::num_ports-1:0] out_in_pkt;
   int                            out_src [noc_pkg::num_ports];
   logic [noc_pkg::num_ports-1:0] stall_q;
   noc_pkg::flit_t                stall_flit [noc_pkg::num_ports];

   noc_router i_dut (
      .clk       (clk),
      .rst       (rst),
      .in_flit   (in_flit),
      .in_valid  (in_valid),
      .in_ready  (in_ready),
      .out_flit  (out_flit),
      .out_valid (out_valid),
      .out_ready (out_ready)
   );

   // 40 ns period.
   always #20 clk = ~clk;

   // next flit of a source with random bits, sequence, source and destination in the payload.
   function automatic noc_pkg::flit_t make_flit(input int src);
      noc_pkg::flit_t f;
      logic [15:0]    r;
      r       = rand_bits(16);
      f.first = (cur[src].pos == 3'd0);
      f.last  = (cur[src].pos == cur[src].len - 3'd1);
      f.data  = {r, seq[src], noc_pkg::port_t'(src), cur[src].dst};
      seq[src] = seq[src] + 12'd1;
      return f;
   endfunction

   // true once every source has sent all its packets.
   function automatic logic sources_idle();
      logic idle_all;
      idle_all = 1'b1;
      for (int i = 0; i < noc_pkg::num_ports; i++) begin
         if (pkts_left[i] != 0 || cur[i].len != 3'd0 || in_valid[i]) begin
            idle_all = 1'b0;
         end
      end
      return idle_all;
   endfunction

   // one cycle of the sources just after the edge.
   task automatic drive_inputs();
      for (int i = 0; i < noc_pkg::num_ports; i++) begin
         // held flit was taken at the last edge.
         if (in_fire[i]) begin
            in_valid[i] = 1'b0;
            cur[i].pos  = cur[i].pos + 3'd1;
            if (cur[i].pos == cur[i].len) begin
               cur[i].len = 3'd0;
            end
         end
         if (!in_valid[i]) begin
            if (cur[i].len == 3'd0 && pkts_left[i] > 0) begin
               // directed packets are single flits to output 0.
               cur[i].dst = directed ? noc_pkg::port_t'(0) : noc_pkg::port_t'(rand_bits(2));
               cur[i].len = directed ? 3'd1 : 3'(rand_bits(2)) + 3'd1;
               cur[i].pos = 3'd0;
               pkts_left[i]--;
            end
            // a quarter of the random cycles stay idle.
            if (cur[i].len != 3'd0 && (directed || rand_bits(2) != 0)) begin
               in_flit[i]  = make_flit(i);
               in_valid[i] = 1'b1;
            end
         end
      end
   endtask

   // reset values on the links.
   task automatic check_links_idle();
      assert (out_valid == '0) else report_mismatch("out_valid", out_valid, 34'h0);
      assert (in_ready == '1) else report_mismatch("in_ready", in_ready, 34'hf);
   endtask

   // model entry for a flit accepted on input src.
   task automatic push_expected(input int src, input noc_pkg::flit_t f);
      int q;
      q = src * noc_pkg::num_ports + int'(cur[src].dst);
      assert (exp_wr[q] - exp_rd[q] < q_depth) else report_error("expected queue overflow");
      exp_mem[q][exp_wr[q] % q_depth] = f;
      exp_wr[q]++;
      flits_sent++;
   endtask

   // one flit leaving output j.
   task automatic check_output(input int j, input noc_pkg::flit_t f);
      int             src;
      int             q;
      noc_pkg::flit_t exp;
      src = int'(f.data[3:2]);
      q   = src * noc_pkg::num_ports + j;
      flits_recv++;
      // packets stay whole on an output.
      if (out_in_pkt[j]) begin
         assert (!f.first && src == out_src[j])
            else report_error($sformatf("output %0d: packet from input %0d cut by input %0d",
                                        j, out_src[j], src));
      end else begin
         assert (f.first) else report_error($sformatf("output %0d: body flit with no head", j));
      end
      out_in_pkt[j] = !f.last;
      out_src[j]    = src;
      assert (exp_rd[q] != exp_wr[q])
         else report_error($sformatf("output %0d: flit from input %0d not expected", j, src));
      if (exp_rd[q] != exp_wr[q]) begin
         exp = exp_mem[q][exp_rd[q] % q_depth];
         assert (f == exp) else report_mismatch($sformatf("out_flit[%0d]", j), f, exp);
         exp_rd[q]++;
      end
      // round-robin order 0,1,2,3 during the directed phase.
      if (fair_phase && j == 0) begin
         assert (src == fair_idx % 4)
            else report_mismatch("source of out_flit[0]", src, fair_idx % 4);
         fair_idx++;
      end
   endtask

   // sample at the falling edge where all links are settled.
   always @(negedge clk) begin
      if (!rst) begin
         for (int i = 0; i < noc_pkg::num_ports; i++) begin
            in_fire[i] = in_valid[i] & in_ready[i];
            if (in_fire[i]) begin
               push_expected(i, in_flit[i]);
            end
         end
         for (int j = 0; j < noc_pkg::num_ports; j++) begin
            // stalled output holds its flit.
            if (stall_q[j]) begin
               assert (out_valid[j]) else report_error($sformatf("out_valid[%0d] dropped", j));
               assert (out_flit[j] == stall_flit[j])
                  else report_mismatch($sformatf("stalled out_flit[%0d]", j),
                                       out_flit[j], stall_flit[j]);
            end
            if (out_valid[j] && out_ready[j]) begin
               check_output(j, out_flit[j]);
            end
            stall_q[j]    = out_valid[j] & ~out_ready[j];
            stall_flit[j] = out_flit[j];
         end
      end else begin
         in_fire = '0;
         stall_q = '0;
      end
   end

   task automatic print_summary();
      $display("summary: %0d flits sent, %0d received, %0d mismatches, %0d other errors",
               flits_sent, flits_recv, mismatch_count, error_count);
   endtask

   // run limit grows with the traffic.
   always @(posedge clk) begin
      cycle_count++;
      if (cycle_count > 20 * flits_sent + 200) begin
         report_error("timeout, traffic did not drain");
         print_summary();
         $display("Checks failed");
         $finish;
      end
   end

   initial begin
      clk            = 1'b0;
      rst            = 1'b1;
      in_valid       = '0;
      out_ready      = '0;
      lfsr_state     = 16'd8101;
      mismatch_count = 0;
      error_count    = 0;
      flits_sent     = 0;
      flits_recv     = 0;
      cycle_count    = 0;
      directed       = 1'b0;
      fair_phase     = 1'b0;
      fair_idx       = 0;
      out_in_pkt     = '0;
      in_fire        = '0;
      stall_q        = '0;
      for (int i = 0; i < noc_pkg::num_ports; i++) begin
         in_flit[i]    = '0;
         cur[i]        = '0;
         pkts_left[i]  = 0;
         seq[i]        = '0;
         out_src[i]    = 0;
         stall_flit[i] = '0;
      end
      for (int q = 0; q < noc_pkg::num_ports * noc_pkg::num_ports; q++) begin
         exp_wr[q] = 0;
         exp_rd[q] = 0;
      end

      // reset for 10 edges with links checked from the second cycle on.
      @(posedge clk);
      repeat (9) begin
         @(negedge clk);
         check_links_idle();
         @(posedge clk);
      end
      #2;
      rst = 1'b0;
      @(negedge clk);
      check_links_idle();

      // output 0 blocked while three packets per input queue up.
      directed   = 1'b1;
      fair_phase = 1'b1;
      out_ready  = 4'b1110;
      for (int i = 0; i < noc_pkg::num_ports; i++) begin
         pkts_left[i] = 3;
      end
      while (!sources_idle()) begin
         @(posedge clk);
         #2;
         drive_inputs();
      end
      repeat (8) @(posedge clk);
      #2;
      out_ready[0] = 1'b1;
      while (fair_idx < 12) @(posedge clk);
      fair_phase = 1'b0;

      // random traffic with random back-pressure.
      directed = 1'b0;
      for (int i = 0; i < noc_pkg::num_ports; i++) begin
         pkts_left[i] = rand_pkts;
      end
      while (!sources_idle()) begin
         @(posedge clk);
         #2;
         for (int j = 0; j < noc_pkg::num_ports; j++) begin
            out_ready[j] = (rand_bits(2) != 0);
         end
         drive_inputs();
      end

      // drain.
      @(posedge clk);
      #2;
      out_ready = '1;
      while (flits_recv < flits_sent) @(posedge clk);
      repeat (4) @(posedge clk);

      // nothing left over.
      for (int q = 0; q < noc_pkg::num_ports * noc_pkg::num_ports; q++) begin
         assert (exp_rd[q] == exp_wr[q])
            else report_error($sformatf("queue %0d still holds %0d flits",
                                        q, exp_wr[q] - exp_rd[q]));
      end
      assert (out_valid == '0) else report_mismatch("out_valid after drain", out_valid, 34'h0);
      assert (out_in_pkt == '0) else report_error("an output ended inside a packet");

      print_summary();
      if (mismatch_count == 0 && error_count == 0) begin
         $display("All checks passed");
      end else begin
         $display("Checks failed");
      end
      $finish;
   end

endmodule

`default_nettype wire
